//--- source/ext_pkg.sv
// External subsystem package
// Bus structs, copy configuration and status, register map
`default_nettype none

package ext_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  typedef struct packed {
    logic              valid;
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [3:0]        wstrb;
  } reg_req_t;

  typedef struct packed {
    logic              ready;
    logic [DATA_W-1:0] rdata;
    logic              error;
  } reg_rsp_t;

  typedef struct packed {
    logic              req;
    logic              we;
    logic [3:0]        be;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
  } obi_rsp_t;

  typedef struct packed {
    logic [ADDR_W-1:0] src;
    logic [ADDR_W-1:0] dst;
    logic [15:0]       len;
    logic              irq_en;
  } copy_cfg_t;

  typedef struct packed {
    logic busy;
    logic done;
  } copy_status_t;

  // Register byte offsets
  localparam logic [ADDR_W-1:0] REG_SRC    = 32'h00;
  localparam logic [ADDR_W-1:0] REG_DST    = 32'h04;
  localparam logic [ADDR_W-1:0] REG_LEN    = 32'h08;
  localparam logic [ADDR_W-1:0] REG_CTRL   = 32'h0C;
  localparam logic [ADDR_W-1:0] REG_STATUS = 32'h10;

  // Merge a write into an old word under byte strobes
  function automatic logic [DATA_W-1:0] apply_strb(input logic [DATA_W-1:0] old_val,
                                                   input logic [DATA_W-1:0] new_val,
                                                   input logic [3:0]        strb);
    logic [DATA_W-1:0] res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

//--- source/memcopy_regs.sv
// Memory-copy register decoder
// Holds the copy configuration and produces start and clear strobes
`default_nettype none

module memcopy_regs (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  ext_pkg::reg_req_t    reg_req_i,
  output ext_pkg::reg_rsp_t    reg_rsp_o,
  input  ext_pkg::copy_status_t status_i,
  output ext_pkg::copy_cfg_t   cfg_o,
  output logic                 start_o,
  output logic                 clear_done_o
);

  import ext_pkg::*;

  logic [ADDR_W-1:0] src_q;
  logic [ADDR_W-1:0] dst_q;
  logic [15:0]       len_q;
  logic              irq_en_q;

  logic hit_src;
  logic hit_dst;
  logic hit_len;
  logic hit_ctrl;
  logic hit_status;
  logic mapped;
  logic wr_en;

  logic [DATA_W-1:0] src_wr;
  logic [DATA_W-1:0] dst_wr;
  logic [DATA_W-1:0] len_wr;

  assign hit_src    = (reg_req_i.addr == REG_SRC);
  assign hit_dst    = (reg_req_i.addr == REG_DST);
  assign hit_len    = (reg_req_i.addr == REG_LEN);
  assign hit_ctrl   = (reg_req_i.addr == REG_CTRL);
  assign hit_status = (reg_req_i.addr == REG_STATUS);
  assign mapped     = hit_src | hit_dst | hit_len | hit_ctrl | hit_status;
  assign wr_en      = reg_req_i.valid & reg_req_i.write;

  assign src_wr = apply_strb(src_q, reg_req_i.wdata, reg_req_i.wstrb);
  assign dst_wr = apply_strb(dst_q, reg_req_i.wdata, reg_req_i.wstrb);
  assign len_wr = apply_strb({16'h0, len_q}, reg_req_i.wdata, reg_req_i.wstrb);

  // Strobes act on the accepting edge
  assign start_o      = wr_en & hit_ctrl & reg_req_i.wstrb[0] & reg_req_i.wdata[0];
  assign clear_done_o = wr_en & hit_status & reg_req_i.wstrb[0] & reg_req_i.wdata[1];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      src_q    <= '0;
      dst_q    <= '0;
      len_q    <= '0;
      irq_en_q <= 1'b0;
    end else if (wr_en) begin
      if (hit_src) src_q <= src_wr;
      if (hit_dst) dst_q <= dst_wr;
      if (hit_len) len_q <= len_wr[15:0];
      if (hit_ctrl && reg_req_i.wstrb[0]) irq_en_q <= reg_req_i.wdata[1];
    end
  end

  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = reg_req_i.valid & ~mapped;
    reg_rsp_o.rdata = '0;
    if (hit_src)    reg_rsp_o.rdata = src_q;
    if (hit_dst)    reg_rsp_o.rdata = dst_q;
    if (hit_len)    reg_rsp_o.rdata = {16'h0, len_q};
    if (hit_ctrl)   reg_rsp_o.rdata = {30'h0, irq_en_q, 1'b0};
    if (hit_status) reg_rsp_o.rdata = {30'h0, status_i.done, status_i.busy};
  end

  assign cfg_o.src    = src_q;
  assign cfg_o.dst    = dst_q;
  assign cfg_o.len    = len_q;
  assign cfg_o.irq_en = irq_en_q;

endmodule

`default_nettype wire

//--- source/memcopy_engine.sv
// Memory-copy engine
// Reads each source word and writes it to the destination, one at a time
`default_nettype none

module memcopy_engine (
  input  logic               clk_i,
  input  logic               rst_i,
  input  ext_pkg::copy_cfg_t cfg_i,
  input  logic               start_i,
  output ext_pkg::obi_req_t  mem_req_o,
  input  ext_pkg::obi_rsp_t  mem_rsp_i,
  output logic               busy_o,
  output logic               finish_o
);

  import ext_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RD_REQ,
    ST_RD_WAIT,
    ST_WR_REQ,
    ST_WR_WAIT,
    ST_FINISH
  } state_e;

  state_e state_q;
  state_e state_d;

  logic [15:0]       cnt_q;
  logic [ADDR_W-1:0] src_q;
  logic [ADDR_W-1:0] dst_q;
  logic [DATA_W-1:0] data_q;

  logic accepted;

  assign accepted = mem_req_o.req & mem_rsp_i.gnt;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (start_i) begin
          state_d = (cfg_i.len == 16'd0) ? ST_FINISH : ST_RD_REQ;
        end
      end
      ST_RD_REQ: begin
        if (accepted) state_d = ST_RD_WAIT;
      end
      ST_RD_WAIT: begin
        if (mem_rsp_i.rvalid) state_d = ST_WR_REQ;
      end
      ST_WR_REQ: begin
        if (accepted) state_d = ST_WR_WAIT;
      end
      ST_WR_WAIT: begin
        if (mem_rsp_i.rvalid) begin
          state_d = (cnt_q == 16'd1) ? ST_FINISH : ST_RD_REQ;
        end
      end
      ST_FINISH: state_d = ST_IDLE;
      default:   state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == ST_IDLE && start_i) begin
        cnt_q <= cfg_i.len;
      end else if (state_q == ST_WR_WAIT && mem_rsp_i.rvalid) begin
        cnt_q <= cnt_q - 16'd1;
      end
    end
  end

  // Addresses and data word, latched so register writes cannot disturb a copy
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && start_i) begin
      src_q <= cfg_i.src;
      dst_q <= cfg_i.dst;
    end else if (state_q == ST_WR_WAIT && mem_rsp_i.rvalid) begin
      src_q <= src_q + 32'd4;
      dst_q <= dst_q + 32'd4;
    end
    if (state_q == ST_RD_WAIT && mem_rsp_i.rvalid) begin
      data_q <= mem_rsp_i.rdata;
    end
  end

  always_comb begin
    mem_req_o.req   = (state_q == ST_RD_REQ) || (state_q == ST_WR_REQ);
    mem_req_o.we    = (state_q == ST_WR_REQ);
    mem_req_o.be    = 4'hF;
    mem_req_o.addr  = (state_q == ST_WR_REQ) ? dst_q : src_q;
    mem_req_o.wdata = data_q;
  end

  assign busy_o   = (state_q != ST_IDLE);
  assign finish_o = (state_q == ST_FINISH);

endmodule

`default_nettype wire

//--- source/memcopy_status.sv
// Memory-copy status
// Sticky done flag and one-cycle completion interrupt
`default_nettype none

module memcopy_status (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  busy_i,
  input  logic                  finish_i,
  input  logic                  clear_done_i,
  input  logic                  irq_en_i,
  output ext_pkg::copy_status_t status_o,
  output logic                  intr_o
);

  import ext_pkg::*;

  logic done_q;
  logic intr_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      done_q <= 1'b0;
      intr_q <= 1'b0;
    end else begin
      // Finish has priority over a clear in the same cycle
      if (finish_i) begin
        done_q <= 1'b1;
      end else if (clear_done_i) begin
        done_q <= 1'b0;
      end
      intr_q <= finish_i & irq_en_i;
    end
  end

  assign status_o.busy = busy_i;
  assign status_o.done = done_q;
  assign intr_o        = intr_q;

endmodule

`default_nettype wire

//--- source/obi_arbiter.sv
// Two-master fixed-priority arbiter for the memory port
// Master 0 wins; responses return to the owner of the last grant
`default_nettype none

module obi_arbiter (
  input  logic              clk_i,
  input  logic              rst_i,
  input  ext_pkg::obi_req_t m0_req_i,
  output ext_pkg::obi_rsp_t m0_rsp_o,
  input  ext_pkg::obi_req_t m1_req_i,
  output ext_pkg::obi_rsp_t m1_rsp_o,
  output ext_pkg::obi_req_t s_req_o,
  input  ext_pkg::obi_rsp_t s_rsp_i
);

  import ext_pkg::*;

  logic sel_m1;
  logic owner_m1_q;

  assign sel_m1  = ~m0_req_i.req;
  assign s_req_o = sel_m1 ? m1_req_i : m0_req_i;

  // Owner of the grant, for the response one cycle later
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      owner_m1_q <= 1'b0;
    end else if (s_req_o.req && s_rsp_i.gnt) begin
      owner_m1_q <= sel_m1;
    end
  end

  always_comb begin
    m0_rsp_o.gnt    = s_rsp_i.gnt & ~sel_m1;
    m0_rsp_o.rvalid = s_rsp_i.rvalid & ~owner_m1_q;
    m0_rsp_o.rdata  = owner_m1_q ? '0 : s_rsp_i.rdata;

    m1_rsp_o.gnt    = s_rsp_i.gnt & sel_m1 & m1_req_i.req;
    m1_rsp_o.rvalid = s_rsp_i.rvalid & owner_m1_q;
    m1_rsp_o.rdata  = owner_m1_q ? s_rsp_i.rdata : '0;
  end

endmodule

`default_nettype wire

//--- source/slow_memory.sv
// Slow word memory
// Grants after GNT_WAIT cycles of request, answers one cycle after grant
`default_nettype none

module slow_memory #(
  parameter int unsigned NUM_WORDS = 128,
  parameter int unsigned GNT_WAIT  = 2
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  ext_pkg::obi_req_t req_i,
  output ext_pkg::obi_rsp_t rsp_o
);

  import ext_pkg::*;

  localparam int unsigned IDX_W = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1;
  localparam int unsigned CNT_W = $clog2(GNT_WAIT + 2);

  logic [DATA_W-1:0] mem_q [NUM_WORDS];
  logic [DATA_W-1:0] rdata_q;
  logic              rvalid_q;
  logic [CNT_W-1:0]  wait_q;

  logic             gnt;
  logic             accepted;
  logic [IDX_W-1:0] word_idx;

  assign gnt      = req_i.req && (wait_q == CNT_W'(GNT_WAIT));
  assign accepted = req_i.req & gnt;
  assign word_idx = IDX_W'((req_i.addr >> 2) % NUM_WORDS);

  // Wait counter restarts after each grant
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wait_q   <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= accepted;
      if (!req_i.req || gnt) begin
        wait_q <= '0;
      end else begin
        wait_q <= wait_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accepted) begin
      rdata_q <= mem_q[word_idx];
      if (req_i.we) begin
        mem_q[word_idx] <= apply_strb(mem_q[word_idx], req_i.wdata, req_i.be);
      end
    end
  end

  assign rsp_o.gnt    = gnt;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;

endmodule

`default_nettype wire

//--- source/ext_subsys_top.sv
// External device subsystem
// Memory-copy peripheral and host port sharing a slow memory
`default_nettype none

module ext_subsys_top #(
  parameter int unsigned NUM_WORDS = 128,
  parameter int unsigned GNT_WAIT  = 2
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  ext_pkg::reg_req_t reg_req_i,
  output ext_pkg::reg_rsp_t reg_rsp_o,
  input  ext_pkg::obi_req_t host_req_i,
  output ext_pkg::obi_rsp_t host_rsp_o,
  output logic              intr_o
);

  import ext_pkg::*;

  copy_cfg_t    cfg;
  copy_status_t status;
  logic         start;
  logic         clear_done;
  logic         busy;
  logic         finish;

  obi_req_t eng_req;
  obi_rsp_t eng_rsp;
  obi_req_t mem_req;
  obi_rsp_t mem_rsp;

  memcopy_regs u_regs (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .reg_req_i    (reg_req_i),
    .reg_rsp_o    (reg_rsp_o),
    .status_i     (status),
    .cfg_o        (cfg),
    .start_o      (start),
    .clear_done_o (clear_done)
  );

  memcopy_engine u_engine (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .cfg_i     (cfg),
    .start_i   (start),
    .mem_req_o (eng_req),
    .mem_rsp_i (eng_rsp),
    .busy_o    (busy),
    .finish_o  (finish)
  );

  memcopy_status u_status (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .busy_i       (busy),
    .finish_i     (finish),
    .clear_done_i (clear_done),
    .irq_en_i     (cfg.irq_en),
    .status_o     (status),
    .intr_o       (intr_o)
  );

  // Engine is master 0, host is master 1
  obi_arbiter u_arbiter (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .m0_req_i (eng_req),
    .m0_rsp_o (eng_rsp),
    .m1_req_i (host_req_i),
    .m1_rsp_o (host_rsp_o),
    .s_req_o  (mem_req),
    .s_rsp_i  (mem_rsp)
  );

  slow_memory #(
    .NUM_WORDS (NUM_WORDS),
    .GNT_WAIT  (GNT_WAIT)
  ) u_memory (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (mem_req),
    .rsp_o (mem_rsp)
  );

endmodule

`default_nettype wire

//--- tests/ext_subsys_asserts.sv
// Protocol assertions for the external subsystem
// Memory handshake timing, request stability and interrupt width
`default_nettype none

module ext_subsys_asserts (
  input logic              clk_i,
  input logic              rst_i,
  input ext_pkg::obi_req_t eng_req_i,
  input ext_pkg::obi_rsp_t eng_rsp_i,
  input ext_pkg::obi_req_t host_req_i,
  input ext_pkg::obi_rsp_t host_rsp_i,
  input logic              intr_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // Responses must reach the master that owns the grant
  eng_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
    (eng_req_i.req && eng_rsp_i.gnt) |=> eng_rsp_i.rvalid)
    else $error("engine rvalid missing one cycle after its grant");

  eng_rvalid_needs_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
    eng_rsp_i.rvalid |-> $past(eng_req_i.req && eng_rsp_i.gnt))
    else $error("engine rvalid without an engine grant in the cycle before");

  host_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
    (host_req_i.req && host_rsp_i.gnt) |=> host_rsp_i.rvalid)
    else $error("host rvalid missing one cycle after its grant");

  host_rvalid_needs_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
    host_rsp_i.rvalid |-> $past(host_req_i.req && host_rsp_i.gnt))
    else $error("host rvalid without a host grant in the cycle before");

  // A waiting master keeps its request unchanged
  eng_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
    (eng_req_i.req && !eng_rsp_i.gnt) |=> (eng_req_i.req && $stable(eng_req_i)))
    else $error("engine request changed before its grant");

  host_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
    (host_req_i.req && !host_rsp_i.gnt) |=> (host_req_i.req && $stable(host_req_i)))
    else $error("host request changed before its grant");

  intr_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    intr_i |=> !intr_i)
    else $error("interrupt held for more than one cycle");

endmodule

bind ext_subsys_top ext_subsys_asserts u_asserts (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .eng_req_i  (eng_req),
  .eng_rsp_i  (eng_rsp),
  .host_req_i (host_req_i),
  .host_rsp_i (host_rsp_o),
  .intr_i     (intr_o)
);

`default_nettype wire

//--- tests/ext_checker.sv
// Response checker for the external subsystem
// Compares register and host read data with queued model values
`default_nettype none

module ext_checker (
  input  logic              clk_i,
  input  logic              rst_i,
  input  ext_pkg::reg_req_t reg_req_i,
  input  ext_pkg::reg_rsp_t reg_rsp_i,
  input  ext_pkg::obi_req_t host_req_i,
  input  ext_pkg::obi_rsp_t host_rsp_i,
  input  logic              intr_i,
  output int unsigned       errors_o,
  output int unsigned       compares_o,
  output int unsigned       intr_count_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // Entries are {error, rdata}
  logic [32:0] reg_exp_q [$];
  logic [31:0] host_exp_q [$];

  int unsigned errors;
  int unsigned compares;
  int unsigned intr_count;
  logic        xfer_pending;
  logic        rd_pending;

  initial begin
    errors       = 0;
    compares     = 0;
    intr_count   = 0;
    xfer_pending = 1'b0;
    rd_pending   = 1'b0;
  end

  assign errors_o     = errors;
  assign compares_o   = compares;
  assign intr_count_o = intr_count;

  task automatic push_reg_exp(input logic [31:0] rdata, input logic err);
    reg_exp_q.push_back({err, rdata});
  endtask

  task automatic push_host_exp(input logic [31:0] rdata);
    host_exp_q.push_back(rdata);
  endtask

  task automatic check_intr_count(input int unsigned expected);
    compares++;
    if (intr_count != expected) begin
      errors++;
      $display("mismatch at %0t: %0d interrupt pulses, expected %0d",
               $time, intr_count, expected);
    end
  endtask

  task automatic check_drained();
    if (reg_exp_q.size() != 0 || host_exp_q.size() != 0) begin
      errors++;
      $display("%0d register and %0d host read responses never arrived",
               reg_exp_q.size(), host_exp_q.size());
    end
  endtask

  always @(posedge clk_i) begin
    logic [32:0] exp_reg;
    logic [31:0] exp_host;
    if (!rst_i) begin
      if (reg_req_i.valid && !reg_req_i.write) begin
        if (reg_exp_q.size() == 0) begin
          errors++;
          $display("register read at %0t had no expected value", $time);
        end else begin
          exp_reg = reg_exp_q.pop_front();
          compares++;
          if (reg_rsp_i.ready !== 1'b1 || reg_rsp_i.rdata !== exp_reg[31:0] ||
              reg_rsp_i.error !== exp_reg[32]) begin
            errors++;
            $display("mismatch at %0t: reg 0x%08h read 0x%08h err %0b, expected 0x%08h err %0b",
                     $time, reg_req_i.addr, reg_rsp_i.rdata, reg_rsp_i.error,
                     exp_reg[31:0], exp_reg[32]);
          end
        end
      end else if (reg_req_i.valid && (reg_rsp_i.ready !== 1'b1 || reg_rsp_i.error !== 1'b0)) begin
        errors++;
        $display("mismatch at %0t: reg write to 0x%08h not accepted cleanly",
                 $time, reg_req_i.addr);
      end

      if (host_rsp_i.rvalid) begin
        if (!xfer_pending) begin
          errors++;
          $display("host rvalid at %0t came without a granted transfer", $time);
        end else if (rd_pending) begin
          if (host_exp_q.size() == 0) begin
            errors++;
            $display("host read data at %0t had no expected value", $time);
          end else begin
            exp_host = host_exp_q.pop_front();
            compares++;
            if (host_rsp_i.rdata !== exp_host) begin
              errors++;
              $display("mismatch at %0t: host read 0x%08h, expected 0x%08h",
                       $time, host_rsp_i.rdata, exp_host);
            end
          end
        end
      end
      xfer_pending = host_req_i.req && host_rsp_i.gnt;
      rd_pending   = xfer_pending && !host_req_i.we;

      if (intr_i) begin
        intr_count <= intr_count + 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_ext_subsys.sv
// Testbench for the external subsystem
// Random register, host and copy traffic checked against a word model
`default_nettype none

module tb_ext_subsys;

  timeunit 1ns;
  timeprecision 100ps;

  import ext_pkg::*;

  localparam int unsigned NUM_WORDS  = 128;
  localparam int unsigned GNT_WAIT   = 2;
  localparam int unsigned N_REG      = 8;
  localparam int unsigned N_HOST     = 32;
  localparam int unsigned N_COPY     = 4;
  localparam int unsigned N_CONT     = 6;
  localparam int unsigned MAX_LEN    = 16;
  // Engine priority can hold a host request for a whole copy
  localparam int unsigned GNT_LIMIT  = 4 * MAX_LEN * (GNT_WAIT + 2) + 32;
  localparam int unsigned INTR_LIMIT = 2 * MAX_LEN * 32;
  localparam int unsigned CLK_PERIOD = 40;

  // Init, one scan per copy and a spare scan, plus register and copy traffic
  localparam int unsigned PLANNED_OPS = NUM_WORDS * (N_COPY + 3) + N_REG * 8 + N_HOST
                                        + 2 * N_COPY * MAX_LEN + 64;
  localparam int unsigned OP_CYCLES   = 16;
  localparam longint      TIMEOUT_NS  = 64'(PLANNED_OPS) * OP_CYCLES * CLK_PERIOD;

  logic        clk;
  logic        rst;
  reg_req_t    reg_req;
  reg_rsp_t    reg_rsp;
  obi_req_t    host_req;
  obi_rsp_t    host_rsp;
  logic        intr;
  int unsigned ck_errors;
  int unsigned ck_compares;
  int unsigned intr_count;
  int unsigned tb_errors;
  integer      seed;

  // Reference model of the memory and the copy registers
  logic [31:0] model_mem [NUM_WORDS];
  logic [31:0] m_src;
  logic [31:0] m_dst;
  logic [15:0] m_len;
  logic        m_done;

  ext_subsys_top #(
    .NUM_WORDS (NUM_WORDS),
    .GNT_WAIT  (GNT_WAIT)
  ) u_ext_subsys_top (
    .clk_i      (clk),
    .rst_i      (rst),
    .reg_req_i  (reg_req),
    .reg_rsp_o  (reg_rsp),
    .host_req_i (host_req),
    .host_rsp_o (host_rsp),
    .intr_o     (intr)
  );

  ext_checker u_checker (
    .clk_i        (clk),
    .rst_i        (rst),
    .reg_req_i    (reg_req),
    .reg_rsp_i    (reg_rsp),
    .host_req_i   (host_req),
    .host_rsp_i   (host_rsp),
    .intr_i       (intr),
    .errors_o     (ck_errors),
    .compares_o   (ck_compares),
    .intr_count_o (intr_count)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  be);
    logic [31:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [31:0] status_word(input logic busy);
    return {30'h0, m_done, busy};
  endfunction

  // Word index outside both copy regions
  function automatic int unsigned pick_outside(input int unsigned src_w,
                                               input int unsigned dst_w,
                                               input int unsigned len);
    int unsigned idx;
    idx = rand_below(NUM_WORDS);
    while ((idx >= src_w && idx < src_w + len) || (idx >= dst_w && idx < dst_w + len)) begin
      idx = rand_below(NUM_WORDS);
    end
    return idx;
  endfunction

  task automatic reg_access(input logic write, input logic [31:0] addr, input logic [31:0] wdata);
    @(negedge clk);
    reg_req.valid = 1'b1;
    reg_req.write = write;
    reg_req.addr  = addr;
    reg_req.wdata = wdata;
    reg_req.wstrb = 4'hF;
    @(negedge clk);
    reg_req = '0;
  endtask

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] wdata);
    case (addr)
      REG_SRC:    m_src = wdata;
      REG_DST:    m_dst = wdata;
      REG_LEN:    m_len = wdata[15:0];
      REG_STATUS: if (wdata[1]) m_done = 1'b0;
      default: ;
    endcase
    reg_access(1'b1, addr, wdata);
  endtask

  task automatic reg_read_check(input logic [31:0] addr, input logic [31:0] exp_data,
                                input logic exp_err);
    u_checker.push_reg_exp(exp_data, exp_err);
    reg_access(1'b0, addr, 32'h0);
  endtask

  task automatic host_xfer(input logic we, input int unsigned idx, input logic [31:0] wdata,
                           input logic [3:0] be);
    int unsigned waited;
    logic        granted;
    @(negedge clk);
    host_req.req   = 1'b1;
    host_req.we    = we;
    host_req.be    = be;
    host_req.addr  = idx * 4;
    host_req.wdata = wdata;
    if (we) begin
      model_mem[idx] = merge_bytes(model_mem[idx], wdata, be);
    end else begin
      u_checker.push_host_exp(model_mem[idx]);
    end
    waited = 0;
    @(posedge clk);
    while (host_rsp.gnt !== 1'b1 && waited < GNT_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    granted = (host_rsp.gnt === 1'b1);
    @(negedge clk);
    host_req = '0;
    if (!granted) begin
      tb_errors++;
      $display("host request for word %0d was never granted", idx);
    end else begin
      @(posedge clk);
      if (host_rsp.rvalid !== 1'b1) begin
        tb_errors++;
        $display("host rvalid did not follow the grant for word %0d", idx);
      end
    end
  endtask

  task automatic verify_memory();
    for (int i = 0; i < NUM_WORDS; i++) begin
      host_xfer(1'b0, i, 32'h0, 4'h0);
    end
  endtask

  task automatic wait_intr(input int unsigned target);
    int unsigned waited;
    waited = 0;
    while (intr_count < target && waited < INTR_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (intr_count < target) begin
      tb_errors++;
      $display("copy raised no interrupt within %0d cycles", INTR_LIMIT);
    end
  endtask

  task automatic pick_regions(input int unsigned len, output int unsigned src_w,
                              output int unsigned dst_w);
    src_w = rand_below(NUM_WORDS - len + 1);
    do begin
      dst_w = rand_below(NUM_WORDS - len + 1);
    end while (dst_w < src_w + len && src_w < dst_w + len);
  endtask

  task automatic run_copy(input int unsigned src_w, input int unsigned dst_w,
                          input int unsigned len, input logic contend);
    logic [31:0] snap [MAX_LEN];
    int unsigned intr_before;
    int unsigned idx;
    for (int i = 0; i < len; i++) snap[i] = model_mem[src_w + i];
    reg_write(REG_SRC, src_w * 4);
    reg_write(REG_DST, dst_w * 4);
    reg_write(REG_LEN, len);
    intr_before = intr_count;
    reg_write(REG_CTRL, 32'h3);
    for (int i = 0; i < len; i++) model_mem[dst_w + i] = snap[i];
    if (len != 0) begin
      reg_read_check(REG_STATUS, status_word(1'b1), 1'b0);
      // New source and a second start while busy
      reg_write(REG_SRC, rand_word());
      reg_write(REG_CTRL, 32'h3);
      if (contend) begin
        for (int i = 0; i < N_CONT; i++) begin
          idx = pick_outside(src_w, dst_w, len);
          if (i % 2 == 1) host_xfer(1'b1, idx, rand_word(), 4'hF);
          else host_xfer(1'b0, idx, 32'h0, 4'h0);
        end
      end
    end
    wait_intr(intr_before + 1);
    m_done = 1'b1;
    reg_read_check(REG_STATUS, status_word(1'b0), 1'b0);
    verify_memory();
    u_checker.check_intr_count(intr_before + 1);
    reg_read_check(REG_STATUS, status_word(1'b0), 1'b0);
    reg_write(REG_STATUS, 32'h2);
    reg_read_check(REG_STATUS, status_word(1'b0), 1'b0);
  endtask

  initial begin
    int unsigned src_w;
    int unsigned dst_w;
    int unsigned len;
    int unsigned idx;
    seed      = 32'hbff5_4a8c;
    tb_errors = 0;
    rst       = 1'b1;
    reg_req   = '0;
    host_req  = '0;
    m_src     = '0;
    m_dst     = '0;
    m_len     = '0;
    m_done    = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    reg_read_check(REG_STATUS, status_word(1'b0), 1'b0);
    u_checker.check_intr_count(0);

    for (int i = 0; i < N_REG; i++) begin
      reg_write(REG_SRC, rand_word());
      reg_write(REG_DST, rand_word());
      reg_write(REG_LEN, rand_word());
      reg_read_check(REG_SRC, m_src, 1'b0);
      reg_read_check(REG_DST, m_dst, 1'b0);
      reg_read_check(REG_LEN, {16'h0, m_len}, 1'b0);
    end
    reg_read_check(32'h14 + 4 * rand_below(40), 32'h0, 1'b1);

    for (int i = 0; i < NUM_WORDS; i++) host_xfer(1'b1, i, rand_word(), 4'hF);
    for (int i = 0; i < N_HOST; i++) begin
      idx = rand_below(NUM_WORDS);
      if (rand_below(2) == 1) host_xfer(1'b1, idx, rand_word(), 4'(rand_below(16)));
      else host_xfer(1'b0, idx, 32'h0, 4'h0);
    end
    idx = rand_below(NUM_WORDS);
    host_xfer(1'b1, idx, rand_word(), 4'b0101);
    host_xfer(1'b0, idx, 32'h0, 4'h0);
    verify_memory();

    // Odd copies run with host traffic beside them
    for (int c = 0; c < N_COPY; c++) begin
      len = 2 + rand_below(MAX_LEN - 1);
      pick_regions(len, src_w, dst_w);
      run_copy(src_w, dst_w, len, (c % 2) == 1);
    end
    run_copy(rand_below(NUM_WORDS), rand_below(NUM_WORDS), 0, 1'b0);

    u_checker.check_drained();
    $display("Summary: %0d checker errors, %0d testbench errors, %0d compares",
             ck_errors, tb_errors, ck_compares);
    if (ck_errors + tb_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns before the run completed", TIMEOUT_NS);
    $display("Summary: %0d checker errors, %0d testbench errors, %0d compares",
             ck_errors, tb_errors, ck_compares);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
source/ext_pkg.sv
source/memcopy_regs.sv
source/memcopy_engine.sv
source/memcopy_status.sv
source/obi_arbiter.sv
source/slow_memory.sv
source/ext_subsys_top.sv
tests/ext_subsys_asserts.sv
tests/ext_checker.sv
tests/tb_ext_subsys.sv
